// ==== source/periph_consts.svh ====
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus and pin widths.
`define PERIPH_ADDR_W 8
`define PERIPH_DATA_W 32
`define GPIO_WIDTH    32

`define REG_GPIO_IO0  8'h00
`define REG_GPIO_DIR0 8'h04
`define REG_GPIO_IO1  8'h08
`define REG_GPIO_DIR1 8'h0C

`define REG_TMR_COUNT 8'h20
`define REG_TMR_CMP   8'h24
`define REG_TMR_CTRL  8'h28 // Bit 0 count enable, bit 1 irq enable.
`define REG_TMR_STAT  8'h2C // Bit 0 match flag, write 1 to clear.

`define TMR_CTRL_EN_BIT 0
`define TMR_CTRL_IE_BIT 1

// Region decode.
`define GPIO_BASE   8'h00
`define TIMER_BASE  8'h20
`define REGION_MASK 8'hE0

`endif

// ==== source/periph_pkg.sv ====
`default_nettype none

`include "periph_consts.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] data_t;
    typedef logic [`GPIO_WIDTH-1:0]    gpio_word_t;

    // One host access.
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  write;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;    // Unmapped address.
    } bus_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } bridge_state_t;

endpackage

`default_nettype wire

// ==== source/bus_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_bridge import periph_pkg::*; (
    input  wire            clk_bus,
    input  wire            rst_n,
    input  wire bus_req_t  req_i,
    input  wire            req_valid_i,
    output logic           req_ready_o,
    output bus_rsp_t       rsp_o,
    output logic           rsp_valid_o,
    input  wire            rsp_ready_i,
    output addr_t          bus_addr_o,
    output data_t          bus_wdata_o,
    output logic           bus_read_o,
    output logic           bus_write_o,
    input  wire data_t     bus_rdata_i,
    input  wire            bus_err_i
);

    bridge_state_t state_q;
    bus_req_t      req_q;
    logic          capture;

    assign req_ready_o = (state_q == IDLE);
    assign capture     = (state_q == RESP) && !rsp_valid_o; // First RESP cycle.

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            rsp_valid_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        state_q <= ACCESS;
                    end
                end
                ACCESS: begin
                    state_q <= RESP;
                end
                RESP: begin
                    if (capture) begin
                        rsp_valid_o <= 1'b1;
                    end else if (rsp_ready_i) begin
                        rsp_valid_o <= 1'b0; // Handshake done.
                        state_q     <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_bus) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        // Registered peripheral data is valid only in this cycle.
        if (capture) begin
            rsp_o.rdata <= bus_rdata_i;
            rsp_o.err   <= bus_err_i;
        end
    end

    assign bus_addr_o  = req_q.addr;
    assign bus_wdata_o = req_q.wdata;
    assign bus_read_o  = (state_q == ACCESS) && !req_q.write;
    assign bus_write_o = (state_q == ACCESS) && req_q.write;

endmodule

`default_nettype wire

// ==== source/periph_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_consts.svh"

module periph_decode import periph_pkg::*; (
    input  wire         clk_bus,
    input  wire         rst_n,
    input  wire addr_t  bus_addr_i,
    input  wire         bus_read_i,
    input  wire         bus_write_i,
    output logic        gpio_read_o,
    output logic        gpio_write_o,
    output logic        tmr_read_o,
    output logic        tmr_write_o,
    input  wire data_t  gpio_rdata_i,
    input  wire data_t  tmr_rdata_i,
    output data_t       bus_rdata_o,
    output logic        bus_err_o
);

    logic gpio_hit;
    logic tmr_hit;
    logic sel_gpio_q;
    logic sel_tmr_q;

    assign gpio_hit = (bus_addr_i & `REGION_MASK) == `GPIO_BASE;
    assign tmr_hit  = (bus_addr_i & `REGION_MASK) == `TIMER_BASE;

    assign gpio_read_o  = bus_read_i && gpio_hit;
    assign gpio_write_o = bus_write_i && gpio_hit;
    assign tmr_read_o   = bus_read_i && tmr_hit;
    assign tmr_write_o  = bus_write_i && tmr_hit;

    // Registered alongside the peripheral read data.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            sel_gpio_q <= 1'b0;
            sel_tmr_q  <= 1'b0;
            bus_err_o  <= 1'b0;
        end else begin
            sel_gpio_q <= gpio_read_o;
            sel_tmr_q  <= tmr_read_o;
            bus_err_o  <= (bus_read_i || bus_write_i) && !gpio_hit && !tmr_hit;
        end
    end

    always_comb begin
        if (sel_gpio_q) begin
            bus_rdata_o = gpio_rdata_i;
        end else if (sel_tmr_q) begin
            bus_rdata_o = tmr_rdata_i;
        end else begin
            bus_rdata_o = '0; // Unmapped or no read.
        end
    end

endmodule

`default_nettype wire

// ==== source/gpio_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_consts.svh"

module gpio_top import periph_pkg::*; (
    input  wire              clk_bus,
    input  wire              rst_n,
    input  wire addr_t       bus_address_i,
    input  wire data_t       bus_data_i,
    output data_t            bus_data_o,
    input  wire              bus_read_i,
    input  wire              bus_write_i,
    input  wire gpio_word_t  gpio0_in_i,
    input  wire gpio_word_t  gpio1_in_i,
    output gpio_word_t       gpio0_out_o,
    output gpio_word_t       gpio0_oe_o,
    output gpio_word_t       gpio1_out_o,
    output gpio_word_t       gpio1_oe_o
);

    gpio_word_t [1:0] pin_in;
    gpio_word_t [1:0] sync_meta_q;
    gpio_word_t [1:0] sync_q;
    gpio_word_t [1:0] value_q;
    gpio_word_t [1:0] mode_q;   // 1 drives the pin.

    assign pin_in = {gpio1_in_i, gpio0_in_i};

    // Two-flop input synchroniser.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta_q <= '0;
            sync_q      <= '0;
        end else begin
            sync_meta_q <= pin_in;
            sync_q      <= sync_meta_q;
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            value_q <= '0;
            mode_q  <= '0;
        end else if (bus_write_i) begin
            case (bus_address_i)
                `REG_GPIO_IO0: begin
                    value_q[0] <= bus_data_i;
                end
                `REG_GPIO_DIR0: begin
                    mode_q[0] <= bus_data_i;
                end
                `REG_GPIO_IO1: begin
                    value_q[1] <= bus_data_i;
                end
                `REG_GPIO_DIR1: begin
                    mode_q[1] <= bus_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    assign gpio0_out_o = value_q[0];
    assign gpio0_oe_o  = mode_q[0];
    assign gpio1_out_o = value_q[1];
    assign gpio1_oe_o  = mode_q[1];

    // Read data lives for one cycle after the strobe.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            bus_data_o <= '0;
        end else if (bus_read_i) begin
            case (bus_address_i)
                `REG_GPIO_IO0:  bus_data_o <= sync_q[0];
                `REG_GPIO_DIR0: bus_data_o <= mode_q[0];
                `REG_GPIO_IO1:  bus_data_o <= sync_q[1];
                `REG_GPIO_DIR1: bus_data_o <= mode_q[1];
                default:        bus_data_o <= '0;
            endcase
        end else begin
            bus_data_o <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/sys_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_consts.svh"

module sys_timer import periph_pkg::*; (
    input  wire         clk_bus,
    input  wire         rst_n,
    input  wire addr_t  bus_address_i,
    input  wire data_t  bus_data_i,
    output data_t       bus_data_o,
    input  wire         bus_read_i,
    input  wire         bus_write_i,
    output logic        irq_o
);

    data_t       count_q;
    data_t       cmp_q;
    logic [1:0]  ctrl_q;
    logic        match_q;
    logic        count_en;
    logic        hit;

    assign count_en = ctrl_q[`TMR_CTRL_EN_BIT];
    assign hit      = count_en && (count_q == cmp_q);

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            cmp_q   <= '0;
            ctrl_q  <= '0;
            match_q <= 1'b0;
            irq_o   <= 1'b0;
        end else begin
            if (bus_write_i && bus_address_i == `REG_TMR_COUNT) begin
                count_q <= bus_data_i;
            end else if (count_en) begin
                count_q <= count_q + 1'b1; // Wraps at the top.
            end
            if (bus_write_i && bus_address_i == `REG_TMR_CMP) begin
                cmp_q <= bus_data_i;
            end
            if (bus_write_i && bus_address_i == `REG_TMR_CTRL) begin
                ctrl_q <= bus_data_i[1:0];
            end
            // A new match wins over a clear in the same cycle.
            if (hit) begin
                match_q <= 1'b1;
            end else if (bus_write_i && bus_address_i == `REG_TMR_STAT && bus_data_i[0]) begin
                match_q <= 1'b0;
            end
            irq_o <= match_q && ctrl_q[`TMR_CTRL_IE_BIT];
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            bus_data_o <= '0;
        end else if (bus_read_i) begin
            case (bus_address_i)
                `REG_TMR_COUNT: bus_data_o <= count_q;
                `REG_TMR_CMP:   bus_data_o <= cmp_q;
                `REG_TMR_CTRL:  bus_data_o <= {{(`PERIPH_DATA_W-2){1'b0}}, ctrl_q};
                `REG_TMR_STAT:  bus_data_o <= {{(`PERIPH_DATA_W-1){1'b0}}, match_q};
                default:        bus_data_o <= '0;
            endcase
        end else begin
            bus_data_o <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_top import periph_pkg::*; (
    input  wire              clk_bus,
    input  wire              rst_n,
    input  wire bus_req_t    req_i,
    input  wire              req_valid_i,
    output logic             req_ready_o,
    output bus_rsp_t         rsp_o,
    output logic             rsp_valid_o,
    input  wire              rsp_ready_i,
    input  wire gpio_word_t  gpio0_in_i,
    input  wire gpio_word_t  gpio1_in_i,
    output gpio_word_t       gpio0_out_o,
    output gpio_word_t       gpio0_oe_o,
    output gpio_word_t       gpio1_out_o,
    output gpio_word_t       gpio1_oe_o,
    output logic             irq_o
);

    addr_t bus_addr;
    data_t bus_wdata;
    data_t bus_rdata;
    data_t gpio_rdata;
    data_t tmr_rdata;
    logic  bus_read;
    logic  bus_write;
    logic  bus_err;
    logic  gpio_read;
    logic  gpio_write;
    logic  tmr_read;
    logic  tmr_write;

    bus_bridge u_bridge (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_read_o  (bus_read),
        .bus_write_o (bus_write),
        .bus_rdata_i (bus_rdata),
        .bus_err_i   (bus_err)
    );

    periph_decode u_decode (
        .clk_bus      (clk_bus),
        .rst_n        (rst_n),
        .bus_addr_i   (bus_addr),
        .bus_read_i   (bus_read),
        .bus_write_i  (bus_write),
        .gpio_read_o  (gpio_read),
        .gpio_write_o (gpio_write),
        .tmr_read_o   (tmr_read),
        .tmr_write_o  (tmr_write),
        .gpio_rdata_i (gpio_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .bus_rdata_o  (bus_rdata),
        .bus_err_o    (bus_err)
    );

    gpio_top u_gpio (
        .clk_bus       (clk_bus),
        .rst_n         (rst_n),
        .bus_address_i (bus_addr),
        .bus_data_i    (bus_wdata),
        .bus_data_o    (gpio_rdata),
        .bus_read_i    (gpio_read),
        .bus_write_i   (gpio_write),
        .gpio0_in_i    (gpio0_in_i),
        .gpio1_in_i    (gpio1_in_i),
        .gpio0_out_o   (gpio0_out_o),
        .gpio0_oe_o    (gpio0_oe_o),
        .gpio1_out_o   (gpio1_out_o),
        .gpio1_oe_o    (gpio1_oe_o)
    );

    sys_timer u_timer (
        .clk_bus       (clk_bus),
        .rst_n         (rst_n),
        .bus_address_i (bus_addr),
        .bus_data_i    (bus_wdata),
        .bus_data_o    (tmr_rdata),
        .bus_read_i    (tmr_read),
        .bus_write_i   (tmr_write),
        .irq_o         (irq_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk_bus_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_bus_o = 1'b0;
        forever #HALF_PERIOD clk_bus_o = ~clk_bus_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_bus_o);
        #1;
        rst_n_o = 1'b1; // Released just after an edge.
    end

endmodule

`default_nettype wire

// ==== sim/periph_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_consts.svh"

module periph_assertions import periph_pkg::*; (
    input  wire            clk_bus,
    input  wire            rst_n,
    input  wire            req_ready_i,
    input  wire            rsp_valid_i,
    input  wire            rsp_ready_i,
    input  wire bus_rsp_t  rsp_i,
    input  wire            bus_read_i,
    input  wire            bus_write_i,
    input  wire            tmr_write_i,
    input  wire addr_t     bus_addr_i,
    input  wire data_t     bus_wdata_i,
    input  wire            irq_i
);

    int   fail_count = 0;
    logic ie_q;

    // Shadow of the timer interrupt enable.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            ie_q <= 1'b0;
        end else if (tmr_write_i && bus_addr_i == `REG_TMR_CTRL) begin
            ie_q <= bus_wdata_i[`TMR_CTRL_IE_BIT];
        end
    end

    rsp_held: assert property (@(posedge clk_bus) disable iff (!rst_n)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else begin
            $error("rsp_o changed or rsp_valid_o dropped under back-pressure");
            fail_count = fail_count + 1;
        end

    strobe_excl: assert property (@(posedge clk_bus) disable iff (!rst_n)
        !(bus_read_i && bus_write_i))
        else begin
            $error("bus_read and bus_write high together");
            fail_count = fail_count + 1;
        end

    strobe_single: assert property (@(posedge clk_bus) disable iff (!rst_n)
        bus_read_i || bus_write_i |=> !bus_read_i && !bus_write_i)
        else begin
            $error("bus strobe held for more than one cycle");
            fail_count = fail_count + 1;
        end

    no_accept: assert property (@(posedge clk_bus) disable iff (!rst_n)
        rsp_valid_i |-> !req_ready_i)
        else begin
            $error("req_ready_o high while a response is pending");
            fail_count = fail_count + 1;
        end

    irq_gated: assert property (@(posedge clk_bus) disable iff (!rst_n)
        irq_i |-> $past(ie_q))
        else begin
            $error("irq_o high with the interrupt disabled");
            fail_count = fail_count + 1;
        end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "periph_consts.svh"

module tb_top import periph_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int NUM_RAND     = 40;
    localparam int NUM_REQ      = 22 + NUM_RAND;
    localparam int TIMEOUT_NS   = (NUM_REQ * 40 + RESET_CYCLES) * 10;

    logic       clk_bus;
    logic       rst_n;
    bus_req_t   req;
    logic       req_valid;
    logic       req_ready;
    bus_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    gpio_word_t drv0;
    gpio_word_t drv1;
    gpio_word_t pin0;
    gpio_word_t pin1;
    gpio_word_t out0;
    gpio_word_t oe0;
    gpio_word_t out1;
    gpio_word_t oe1;
    logic       irq;
    logic [7:0] lfsr;
    int         errors;
    int         checks;
    data_t      sb_val [2];
    data_t      sb_dir [2];
    data_t      sb_cmp;

    tb_clock u_clock (.clk_bus_o(clk_bus), .rst_n_o(rst_n));

    // Pad loopback.
    assign pin0 = (out0 & oe0) | (drv0 & ~oe0);
    assign pin1 = (out1 & oe1) | (drv1 & ~oe1);

    periph_top uut (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .gpio0_in_i  (pin0),
        .gpio1_in_i  (pin1),
        .gpio0_out_o (out0),
        .gpio0_oe_o  (oe0),
        .gpio1_out_o (out1),
        .gpio1_oe_o  (oe1),
        .irq_o       (irq)
    );

    bind periph_top periph_assertions u_asrt (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .req_ready_i (req_ready_o),
        .rsp_valid_i (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_i       (rsp_o),
        .bus_read_i  (bus_read),
        .bus_write_i (bus_write),
        .tmr_write_i (tmr_write),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .irq_i       (irq_o)
    );

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // x^8+x^6+x^5+x^4+1.
    endfunction

    function automatic data_t random_bits(input int n);
        data_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[7]};
            lfsr = lfsr_next(lfsr);
        end
        return bits;
    endfunction

    // Register view from the scoreboard and the pad loopback.
    function automatic data_t expected_read(input addr_t addr);
        case (addr)
            `REG_GPIO_IO0:  return (sb_val[0] & sb_dir[0]) | (drv0 & ~sb_dir[0]);
            `REG_GPIO_DIR0: return sb_dir[0];
            `REG_GPIO_IO1:  return (sb_val[1] & sb_dir[1]) | (drv1 & ~sb_dir[1]);
            `REG_GPIO_DIR1: return sb_dir[1];
            `REG_TMR_CMP:   return sb_cmp;
            default:        return '0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk_bus);
        #1;
    endtask

    task automatic expect_value(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s expected %h got %h at %0t ns", name, exp, got, $time);
            errors++;
        end
    endtask

    task automatic issue_access(input addr_t addr, input data_t wdata, input logic is_write,
                                output bus_rsp_t got);
        int hold;
        hold = random_bits(3);
        while (!req_ready) next_cycle();
        req = '{addr: addr, wdata: wdata, write: is_write};
        req_valid = 1'b1;
        next_cycle();
        req = '{addr: `REG_GPIO_DIR1, wdata: ~sb_dir[1], write: 1'b1}; // Must be ignored.
        while (!rsp_valid) next_cycle();
        repeat (hold) next_cycle();
        got = rsp;
        rsp_ready = 1'b1;
        next_cycle();
        rsp_ready = 1'b0;
        req_valid = 1'b0;
    endtask

    task automatic read_check(input addr_t addr, input logic exp_err);
        bus_rsp_t got;
        issue_access(addr, '0, 1'b0, got);
        expect_value("rsp_o.rdata", got.rdata, expected_read(addr));
        expect_value("rsp_o.err", data_t'(got.err), data_t'(exp_err));
    endtask

    task automatic write_reg(input addr_t addr, input data_t data, input logic exp_err);
        bus_rsp_t got;
        issue_access(addr, data, 1'b1, got);
        expect_value("rsp_o.rdata", got.rdata, '0);
        expect_value("rsp_o.err", data_t'(got.err), data_t'(exp_err));
        if (!exp_err) begin
            case (addr)
                `REG_GPIO_IO0:  sb_val[0] = data;
                `REG_GPIO_DIR0: sb_dir[0] = data;
                `REG_GPIO_IO1:  sb_val[1] = data;
                `REG_GPIO_DIR1: sb_dir[1] = data;
                `REG_TMR_CMP:   sb_cmp = data;
                default: begin
                end
            endcase
        end
    endtask

    initial begin
        bus_rsp_t got;
        data_t    first_count;
        data_t    pick;
        data_t    is_wr;
        data_t    wdata;
        addr_t    addr;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        drv0      = '0;
        drv1      = '0;
        lfsr      = 8'd26;
        errors    = 0;
        checks    = 0;
        sb_val    = '{default: '0};
        sb_dir    = '{default: '0};
        sb_cmp    = '0;
        wait (rst_n === 1'b1);
        next_cycle();

        expect_value("rsp_valid_o", data_t'(rsp_valid), '0);
        expect_value("req_ready_o", data_t'(req_ready), 32'h1);
        expect_value("irq_o", data_t'(irq), '0);
        expect_value("gpio0_oe_o", oe0, '0);
        expect_value("gpio1_oe_o", oe1, '0);

        write_reg(`REG_GPIO_DIR0, 32'hFFFF_0000, 1'b0);
        write_reg(`REG_GPIO_IO0, 32'hA5A5_1234, 1'b0);
        write_reg(`REG_GPIO_DIR1, 32'h00FF_00FF, 1'b0);
        write_reg(`REG_GPIO_IO1, 32'h1234_5678, 1'b0);
        expect_value("gpio0_out_o", out0, sb_val[0]);
        expect_value("gpio0_oe_o", oe0, sb_dir[0]);
        expect_value("gpio1_out_o", out1, sb_val[1]);
        expect_value("gpio1_oe_o", oe1, sb_dir[1]);
        read_check(`REG_GPIO_DIR0, 1'b0);
        read_check(`REG_GPIO_DIR1, 1'b0);

        drv0 = 32'h1357_9BDF;
        drv1 = 32'hF0F0_0F0F;
        repeat (3) next_cycle(); // Through the synchroniser.
        read_check(`REG_GPIO_IO0, 1'b0);
        read_check(`REG_GPIO_IO1, 1'b0);

        write_reg(`REG_TMR_COUNT, 32'd0, 1'b0);
        write_reg(`REG_TMR_CMP, 32'd20, 1'b0);
        write_reg(`REG_TMR_CTRL, 32'd3, 1'b0);
        repeat (32) next_cycle();
        issue_access(`REG_TMR_STAT, '0, 1'b0, got);
        expect_value("rsp_o.rdata", got.rdata, 32'h1);
        expect_value("irq_o", data_t'(irq), 32'h1);
        issue_access(`REG_TMR_COUNT, '0, 1'b0, got);
        first_count = got.rdata;
        issue_access(`REG_TMR_COUNT, '0, 1'b0, got);
        checks++;
        assert (got.rdata > first_count) else begin
            $display("Error: rsp_o.rdata count %h not above %h", got.rdata, first_count);
            errors++;
        end
        write_reg(`REG_TMR_STAT, 32'h1, 1'b0);
        expect_value("irq_o", data_t'(irq), '0);
        issue_access(`REG_TMR_STAT, '0, 1'b0, got);
        expect_value("rsp_o.rdata", got.rdata, '0);
        write_reg(`REG_TMR_CTRL, 32'd1, 1'b0);
        write_reg(`REG_TMR_COUNT, 32'd0, 1'b0);
        repeat (32) next_cycle();
        issue_access(`REG_TMR_STAT, '0, 1'b0, got);
        expect_value("rsp_o.rdata", got.rdata, 32'h1);
        expect_value("irq_o", data_t'(irq), '0); // Match with the interrupt disabled.
        write_reg(`REG_TMR_CTRL, 32'd0, 1'b0);

        read_check(8'h40, 1'b1);
        write_reg(8'hC4, 32'hDEAD_BEEF, 1'b1);

        for (int i = 0; i < NUM_RAND; i++) begin
            pick  = random_bits(3);
            is_wr = random_bits(1);
            wdata = random_bits(32);
            if (pick < 4) begin
                addr = {3'b000, pick[1:0], 2'b00};
            end else if (pick < 6) begin
                addr = `REG_TMR_CMP;
            end else begin
                addr = {pick[2:0], 5'h04}; // Outside both regions.
            end
            if (is_wr[0]) begin
                write_reg(addr, wdata, pick >= 6);
            end else begin
                read_check(addr, pick >= 6);
            end
        end

        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_asrt.fail_count);
        if (errors == 0 && uut.u_asrt.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout after %0d ns, an access never completed", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/periph_pkg.sv
source/bus_bridge.sv
source/periph_decode.sv
source/gpio_top.sv
source/sys_timer.sv
source/periph_top.sv
sim/tb_clock.sv
sim/periph_assertions.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f \
    && ./obj_dir/Vtb_top +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -q "^Simulation PASSED$" \
    || { echo "run.sh: simulation did not pass"; exit 1; }
